// File: Makefile
# Verilator build and run for the pulse-shaping FIR filter

VERILATOR ?= verilator
TOP ?= pulseShapeFilterTb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
JOBS ?= 0
VFLAGS ?= --binary --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail, not the exit code of the simulation
run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "** PASS **" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/filterTypesPkg.sv
`default_nettype none

`include "pulseFilter_settings.svh"

package filterTypesPkg;

	// samples inside the filter are 2s16
	typedef logic signed [`SAMPLE_WIDTH-1:0] sampleT;

	// sum of one mirrored tap pair
	typedef sampleT pairSumT;

	// level times coefficient, read from the product table
	typedef sampleT productT;

	// whole delay line
	// index 0 holds the newest sample
	typedef sampleT [`FILT_TAPS-1:0] tapArrayT;

	// delay line after folding
	typedef struct packed {
		// pair i is tap i plus tap 14-i
		pairSumT [`FILT_UNIQUE-2:0] pairSum;
		// tap 7 has no partner
		sampleT center;
	} foldedTapsT;

	// one product per folded tap
	// index 7 belongs to the center
	typedef productT [`FILT_UNIQUE-1:0] productSetT;

endpackage

`default_nettype wire

// File: common/pulseCoeffPkg.sv
`default_nettype none

`include "pulseFilter_settings.svh"

package pulseCoeffPkg;
	import filterTypesPkg::*;

	// half of the symmetric response
	// h0 sits at the outer edge, h7 at the center and is the largest
	localparam sampleT baseCoeff [`FILT_UNIQUE] = '{
		-18'sd1675,
		-18'sd3447,
		-18'sd3357,
		-18'sd585,
		18'sd4552,
		18'sd10581,
		18'sd15419,
		18'sd17267
	};

	// a pair sum carries two symbols, so twice the symbol range
	localparam int LEVEL_MIN = -6;
	localparam int LEVEL_MAX = 6;

	// the center tap carries a single symbol
	localparam int CENTER_MIN = -3;
	localparam int CENTER_MAX = 3;

	// one row per tap, indexed directly by the signed level
	typedef productT [LEVEL_MAX:LEVEL_MIN] levelRowT;
	typedef levelRowT [`FILT_UNIQUE-1:0] productTableT;

	// k times h_i for every tap and every level a pair sum can take
	function automatic productTableT buildProductTable();
		productTableT tbl;
		int prod;
		tbl = '0;
		for (int i = 0; i < `FILT_UNIQUE; i++) begin
			for (int k = LEVEL_MIN; k <= LEVEL_MAX; k++) begin
				prod = k * int'(baseCoeff[i]);
				// keep the low bits, the datapath wraps the same way
				tbl[i][k] = productT'(prod);
			end
		end
		return tbl;
	endfunction

	// built once at elaboration
	// center rows outside CENTER_MIN..CENTER_MAX are never selected
	localparam productTableT productTable = buildProductTable();

endpackage

`default_nettype wire

// File: common/pulseFilter_settings.svh
`ifndef PULSE_FILTER_SETTINGS_SVH
`define PULSE_FILTER_SETTINGS_SVH

// full filter length
`define FILT_TAPS 15

// seven mirrored pairs plus the center tap
`define FILT_UNIQUE 8

// one width for samples, pair sums and products
`define SAMPLE_WIDTH 18

// level grid in the halved 2s16 domain
`define LEVEL_STEP 8192

// exclusive match window around each level
`define LEVEL_TOL 10

// pairwise adder stages from 8 products down to 1
`define TREE_LEVELS 3

`endif

// File: rtl/adderTree.sv
`default_nettype none

`include "pulseFilter_settings.svh"

module adderTree
	import filterTypesPkg::*;
(
	input wire logic sys_clk,
	input wire logic reset,
	input wire logic sampleEn,
	input wire productSetT products,
	output sampleT filtOut
);

	// eight leaves for three pairwise levels
	localparam int LEAVES = 1 << `TREE_LEVELS;

	sampleT [LEAVES/2-1:0] level1;
	sampleT [LEAVES/4-1:0] level2;

	// first level, 8 products into 4 sums
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			level1 <= '0;
		end else if (sampleEn) begin
			for (int i = 0; i < LEAVES / 2; i++) begin
				level1[i] <= products[2*i] + products[2*i+1];
			end
		end
	end

	// second level, 4 into 2
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			level2 <= '0;
		end else if (sampleEn) begin
			for (int i = 0; i < LEAVES / 4; i++) begin
				level2[i] <= level1[2*i] + level1[2*i+1];
			end
		end
	end

	// last level is the filter output
	// all sums wrap at the sample width
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			filtOut <= '0;
		end else if (sampleEn) begin
			filtOut <= level2[0] + level2[1];
		end
	end

endmodule

`default_nettype wire

// File: rtl/levelProductLut.sv
`default_nettype none

`include "pulseFilter_settings.svh"

module levelProductLut
	import filterTypesPkg::*;
	import pulseCoeffPkg::*;
(
	input wire logic sys_clk,
	input wire logic reset,
	input wire logic sampleEn,
	input wire foldedTapsT foldedTaps,
	output productSetT products
);

	productSetT productsNext;

	// value lies strictly inside the window around k times the step
	function automatic logic onLevel(input sampleT value, input int k);
		int diff;
		diff = int'(value) - k * `LEVEL_STEP;
		return (diff > -`LEVEL_TOL) && (diff < `LEVEL_TOL);
	endfunction

	// levels are far apart next to the window
	// so at most one k can hit
	function automatic productT lookupProduct(
		input sampleT value,
		input int tapIdx,
		input int kMin,
		input int kMax
	);
		productT result;
		result = '0;
		for (int k = LEVEL_MIN; k <= LEVEL_MAX; k++) begin
			if ((k >= kMin) && (k <= kMax) && onLevel(value, k)) begin
				result = productTable[tapIdx][k];
			end
		end
		return result;
	endfunction

	always_comb begin
		// pair sums may sit anywhere on the double range
		for (int i = 0; i < `FILT_UNIQUE - 1; i++) begin
			productsNext[i] = lookupProduct(foldedTaps.pairSum[i], i, LEVEL_MIN, LEVEL_MAX);
		end
		// center only matches single symbol levels
		productsNext[`FILT_UNIQUE-1] = lookupProduct(foldedTaps.center, `FILT_UNIQUE - 1,
			CENTER_MIN, CENTER_MAX);
	end

	// off-level inputs contribute nothing
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			products <= '0;
		end else if (sampleEn) begin
			products <= productsNext;
		end
	end

endmodule

`default_nettype wire

// File: rtl/pulseShapeFilter.sv
`default_nettype none

module pulseShapeFilter
	import filterTypesPkg::*;
(
	input wire logic sys_clk,
	input wire logic reset,
	// one cycle strobe per input sample
	input wire logic sampleEn,
	// 1s17 symbol stream
	input wire sampleT sampleIn,
	output sampleT filtOut
);

	foldedTapsT foldedTaps;
	productSetT products;

	// halve, delay and fold
	tapDelayLine u_tapDelayLine (
		.sys_clk(sys_clk),
		.reset(reset),
		.sampleEn(sampleEn),
		.sampleIn(sampleIn),
		.foldedTaps(foldedTaps)
	);

	// multiplier-free products by level lookup
	levelProductLut u_levelProductLut (
		.sys_clk(sys_clk),
		.reset(reset),
		.sampleEn(sampleEn),
		.foldedTaps(foldedTaps),
		.products(products)
	);

	// three registered sum levels
	adderTree u_adderTree (
		.sys_clk(sys_clk),
		.reset(reset),
		.sampleEn(sampleEn),
		.products(products),
		.filtOut(filtOut)
	);

endmodule

`default_nettype wire

// File: rtl/tapDelayLine.sv
`default_nettype none

`include "pulseFilter_settings.svh"

module tapDelayLine
	import filterTypesPkg::*;
(
	input wire logic sys_clk,
	input wire logic reset,
	input wire logic sampleEn,
	input wire sampleT sampleIn,
	output foldedTapsT foldedTaps
);

	tapArrayT taps;
	sampleT halvedIn;
	foldedTapsT foldedNext;

	// 1s17 to 2s16
	// gives the pair sums one bit of headroom
	assign halvedIn = sampleIn >>> 1;

	// newest sample enters at tap 0
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			taps <= '0;
		end else if (sampleEn) begin
			taps <= {taps[`FILT_TAPS-2:0], halvedIn};
		end
	end

	// mirrored taps share a coefficient, so add them first
	always_comb begin
		for (int i = 0; i < `FILT_UNIQUE - 1; i++) begin
			foldedNext.pairSum[i] = taps[i] + taps[`FILT_TAPS-1-i];
		end
		foldedNext.center = taps[`FILT_UNIQUE-1];
	end

	// sums see the taps as they stood before this enable
	// so a new sample reaches foldedTaps one enable after entering tap 0
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			foldedTaps <= '0;
		end else if (sampleEn) begin
			foldedTaps <= foldedNext;
		end
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+common
common/filterTypesPkg.sv
common/pulseCoeffPkg.sv
rtl/tapDelayLine.sv
rtl/levelProductLut.sv
rtl/adderTree.sv
rtl/pulseShapeFilter.sv
verification/pulseShapeFilter_properties.sv
verification/pulseShapeFilterTb.sv

// File: verification/pulseShapeFilterTb.sv
`default_nettype none

`include "pulseFilter_settings.svh"

module pulseShapeFilterTb
	import filterTypesPkg::*;
	import pulseCoeffPkg::*;
();

	localparam int MAX_ROWS = 1024;
	localparam int CLK_PERIOD = 10;
	localparam int PIPE_DEPTH = 5;
	localparam logic [31:0] RNG_SEED = 32'h958e_44e4;

	// one row per clock cycle
	typedef struct packed {
		sampleT sample;
		logic en;
		logic rst;
		logic checkProd;
		sampleT expOut;
		productSetT expProd;
	} stimRowT;

	stimRowT stimTable [MAX_ROWS];
	int numRows;
	logic tableReady;
	logic [31:0] rngState;

	logic sys_clk;
	logic reset;
	logic sampleEn;
	sampleT sampleIn;
	sampleT filtOut;

	pulseShapeFilter u_pulseShapeFilter (
		.sys_clk(sys_clk),
		.reset(reset),
		.sampleEn(sampleEn),
		.sampleIn(sampleIn),
		.filtOut(filtOut)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	function automatic logic [31:0] nextRandom(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// two random bits pick one of the four symbols
	function automatic int symbolFromBits(input logic [1:0] bits);
		int sym;
		case (bits)
			2'd0: sym = -3;
			2'd1: sym = -1;
			2'd2: sym = 1;
			default: sym = 3;
		endcase
		return sym;
	endfunction

	// level k in the 1s17 input domain, twice the halved step
	function automatic sampleT levelSample(input int k);
		return sampleT'(k * 2 * `LEVEL_STEP);
	endfunction

	// round to the nearest level, then test window and allowed range
	function automatic sampleT modelProduct(input sampleT value, input int coeffIdx,
		input int kMin, input int kMax);
		int v;
		int k;
		int offset;
		sampleT result;
		v = int'(value);
		if (v >= 0) begin
			k = (v + `LEVEL_STEP / 2) / `LEVEL_STEP;
		end else begin
			k = -((`LEVEL_STEP / 2 - v) / `LEVEL_STEP);
		end
		offset = v - k * `LEVEL_STEP;
		result = '0;
		if ((k >= kMin) && (k <= kMax) && (offset > -`LEVEL_TOL) && (offset < `LEVEL_TOL)) begin
			result = sampleT'(k * int'(baseCoeff[coeffIdx]));
		end
		return result;
	endfunction

	function automatic productSetT modelProducts(input tapArrayT taps);
		productSetT prods;
		sampleT pair;
		for (int i = 0; i < `FILT_UNIQUE - 1; i++) begin
			pair = sampleT'(taps[i] + taps[`FILT_TAPS-1-i]);
			prods[i] = modelProduct(pair, i, LEVEL_MIN, LEVEL_MAX);
		end
		prods[`FILT_UNIQUE-1] = modelProduct(taps[`FILT_UNIQUE-1], `FILT_UNIQUE - 1,
			CENTER_MIN, CENTER_MAX);
		return prods;
	endfunction

	function automatic sampleT sumProducts(input productSetT prods);
		sampleT acc;
		acc = '0;
		for (int i = 0; i < `FILT_UNIQUE; i++) begin
			acc = acc + prods[i];
		end
		return acc;
	endfunction

	task automatic addRow(input sampleT sample, input logic en, input logic rst,
		input logic checkProd);
		if (numRows >= MAX_ROWS) begin
			$display("stimulus table is full, row %0d does not fit", numRows);
			$display("** FAIL **");
			$fatal(1);
		end
		stimTable[numRows].sample = sample;
		stimTable[numRows].en = en;
		stimTable[numRows].rst = rst;
		stimTable[numRows].checkProd = checkProd;
		stimTable[numRows].expOut = '0;
		stimTable[numRows].expProd = '0;
		numRows++;
	endtask

	task automatic addIdle(input int count, input logic checkProd);
		for (int n = 0; n < count; n++) begin
			addRow('0, 1'b1, 1'b0, checkProd);
		end
	endtask

	// junk samples while disabled, the filter must ignore them
	task automatic addGap(input int count);
		for (int n = 0; n < count; n++) begin
			addRow(levelSample(symbolFromBits(rngState[5:4])), 1'b0, 1'b0, 1'b0);
		end
	endtask

	task automatic addRandomSymbols(input int count, input logic withGaps);
		int gap;
		for (int n = 0; n < count; n++) begin
			rngState = nextRandom(rngState);
			addRow(levelSample(symbolFromBits(rngState[1:0])), 1'b1, 1'b0, 1'b0);
			gap = withGaps ? int'(rngState[9:8]) % 3 : 0;
			addGap(gap);
		end
	endtask

	// one probe sample, flushed through with products checked
	task automatic addProbe(input sampleT sample);
		addRow(sample, 1'b1, 1'b0, 1'b1);
		addIdle(20, 1'b1);
	endtask

	task automatic buildTable();
		numRows = 0;
		rngState = RNG_SEED;
		addIdle(8, 1'b0);
		// +3 impulse walks out the whole response
		addRow(levelSample(3), 1'b1, 1'b0, 1'b0);
		addIdle(24, 1'b0);
		addRandomSymbols(200, 1'b1);
		// long pause in the middle of a stream
		addRandomSymbols(6, 1'b0);
		addGap(7);
		addRandomSymbols(10, 1'b0);
		addIdle(20, 1'b0);
		// inside the window, exact, odd raw values, just outside, halfway
		addProbe(sampleT'(2 * (`LEVEL_STEP + `LEVEL_TOL - 1)));
		addProbe(levelSample(1));
		addProbe(sampleT'(2 * `LEVEL_STEP + 2 * `LEVEL_TOL - 1));
		addProbe(sampleT'(-2 * (3 * `LEVEL_STEP + `LEVEL_TOL - 1)));
		addProbe(sampleT'(-2 * `LEVEL_STEP - 2 * `LEVEL_TOL + 1));
		addProbe(sampleT'(2 * (`LEVEL_STEP + `LEVEL_TOL)));
		addProbe(sampleT'(2 * (`LEVEL_STEP + `LEVEL_STEP / 2)));
		// level 4 is fine for a pair but off-level for the center
		addProbe(levelSample(4));
		// reset with samples in flight
		addRandomSymbols(12, 1'b0);
		addRow(levelSample(1), 1'b1, 1'b1, 1'b0);
		addRow(levelSample(-3), 1'b1, 1'b1, 1'b0);
		addRow(levelSample(-1), 1'b1, 1'b0, 1'b0);
		addIdle(24, 1'b0);
	endtask

	// reference model over the whole table
	task automatic fillExpected();
		tapArrayT taps;
		productSetT prodPipe [2];
		sampleT sumPipe [PIPE_DEPTH];
		productSetT fresh;
		productSetT heldProd;
		sampleT heldOut;
		taps = '0;
		prodPipe[0] = '0;
		prodPipe[1] = '0;
		for (int d = 0; d < PIPE_DEPTH; d++) begin
			sumPipe[d] = '0;
		end
		heldProd = '0;
		heldOut = '0;
		for (int r = 0; r < numRows; r++) begin
			if (stimTable[r].rst) begin
				taps = '0;
				prodPipe[0] = '0;
				prodPipe[1] = '0;
				for (int d = 0; d < PIPE_DEPTH; d++) begin
					sumPipe[d] = '0;
				end
				heldProd = '0;
				heldOut = '0;
			end else if (stimTable[r].en) begin
				for (int i = `FILT_TAPS - 1; i > 0; i--) begin
					taps[i] = taps[i-1];
				end
				taps[0] = stimTable[r].sample >>> 1;
				fresh = modelProducts(taps);
				// products lag two enables, the output five
				heldProd = prodPipe[1];
				prodPipe[1] = prodPipe[0];
				prodPipe[0] = fresh;
				heldOut = sumPipe[PIPE_DEPTH-1];
				for (int d = PIPE_DEPTH - 1; d > 0; d--) begin
					sumPipe[d] = sumPipe[d-1];
				end
				sumPipe[0] = sumProducts(fresh);
			end
			stimTable[r].expOut = heldOut;
			stimTable[r].expProd = heldProd;
		end
	endtask

	task automatic checkSample(input string name, input sampleT actual, input sampleT expected,
		input int row);
		if (actual !== expected) begin
			$display("Error: %s at row %0d is %h, expected %h", name, row, actual, expected);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	task automatic checkProducts(input string name, input productSetT actual,
		input productSetT expected, input int row);
		if (actual !== expected) begin
			$display("Error: %s at row %0d is %h, expected %h", name, row, actual, expected);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	initial begin
		reset = 1'b1;
		sampleEn = 1'b0;
		sampleIn = '0;
		tableReady = 1'b0;
		buildTable();
		fillExpected();
		tableReady = 1'b1;
		repeat (5) @(posedge sys_clk);
		#1;
		reset = 1'b0;
		checkSample("filtOut", filtOut, '0, -1);
		for (int r = 0; r < numRows; r++) begin
			reset = stimTable[r].rst;
			sampleEn = stimTable[r].en;
			sampleIn = stimTable[r].sample;
			@(posedge sys_clk);
			#1;
			checkSample("filtOut", filtOut, stimTable[r].expOut, r);
			if (stimTable[r].checkProd) begin
				checkProducts("u_pulseShapeFilter.products", u_pulseShapeFilter.products,
					stimTable[r].expProd, r);
			end
		end
		$display("** PASS **");
		$finish;
	end

	// generous bound on the table length
	initial begin
		wait (tableReady);
		#(20 * (numRows + 10) * CLK_PERIOD);
		$display("timeout: the stimulus table did not finish in time");
		$display("** FAIL **");
		$fatal(1);
	end

endmodule

`default_nettype wire

// File: verification/pulseShapeFilter_properties.sv
`default_nettype none

`include "pulseFilter_settings.svh"

module pulseShapeFilterProps
	import filterTypesPkg::*;
	import pulseCoeffPkg::*;
(
	input wire logic sys_clk,
	input wire logic reset,
	input wire logic sampleEn,
	input wire foldedTapsT foldedTaps,
	input wire productSetT products,
	input wire sampleT filtOut
);

	logic centerOnLevel;
	int centerValue;

	// center tap inside the window of some single symbol level
	always_comb begin
		centerValue = int'(foldedTaps.center);
		centerOnLevel = 1'b0;
		for (int k = CENTER_MIN; k <= CENTER_MAX; k++) begin
			if ((centerValue - k * `LEVEL_STEP > -`LEVEL_TOL) &&
				(centerValue - k * `LEVEL_STEP < `LEVEL_TOL)) begin
				centerOnLevel = 1'b1;
			end
		end
	end

	resetClearsOutput: assert property (@(posedge sys_clk) reset |=> (filtOut == '0))
		else $error("filtOut is not zero the cycle after reset");

	// idle cycles must not move the output
	holdWhileIdle: assert property (@(posedge sys_clk)
		(!reset && !sampleEn) |=> $stable(filtOut))
		else $error("filtOut changed while sampleEn was low");

	offLevelCenterZero: assert property (@(posedge sys_clk)
		(!reset && sampleEn && !centerOnLevel) |=> (products[`FILT_UNIQUE-1] == '0))
		else $error("center product is not zero for an off-level center tap");

endmodule

bind pulseShapeFilter pulseShapeFilterProps u_pulseShapeFilterProps (
	.sys_clk(sys_clk),
	.reset(reset),
	.sampleEn(sampleEn),
	.foldedTaps(foldedTaps),
	.products(products),
	.filtOut(filtOut)
);

`default_nettype wire
